// ==== flist.f ====
hdl/cache_pkg.sv
hdl/bank_router.sv
hdl/cache_bank.sv
hdl/refill_arbiter.sv
hdl/banked_icache.sv
test/mem_model.sv
test/tb_banked_icache.sv

// ==== hdl/bank_router.sv ====
`timescale 1ns/1ps

module bank_router (
  input  logic                                                     clock,
  input  logic                                                     reset_n,
  input  cache_pkg::cpu_addr_t                                     cpu_addr,
  input  logic                                                     cpu_rd,
  input  logic [cache_pkg::NBANKS-1:0]                             hit_wait,
  input  logic [cache_pkg::NBANKS-1:0]                             bank_rd_valid,
  input  logic [cache_pkg::NBANKS-1:0][cache_pkg::LINE_WIDTH-1:0]  bank_rd_line,
  output logic                                                     cpu_waitrequest,
  output logic                                                     cpu_rd_valid,
  output logic [cache_pkg::LINE_WIDTH-1:0]                         cpu_rd_line,
  output logic [cache_pkg::NBANKS-1:0]                             lookup_rd,
  output cache_pkg::cpu_addr_t                                     lookup_addr,
  output logic [cache_pkg::NBANKS-1:0]                             prefetch,
  output cache_pkg::cpu_addr_t                                     prefetch_addr
);

  logic [cache_pkg::BANK_BITS-1:0] sel_bank;
  logic [cache_pkg::BANK_BITS-1:0] rd_bank;
  logic                            accept;
  logic                            hint_sent;

  assign sel_bank    = cpu_addr.bank_view.bank;
  assign lookup_addr = cpu_addr;

  always_comb begin
    lookup_rd           = '0;
    lookup_rd[sel_bank] = cpu_rd;
  end

  // Only the addressed bank can stall the CPU
  assign cpu_waitrequest = cpu_rd & hit_wait[sel_bank];
  assign accept          = cpu_rd & ~cpu_waitrequest;

  // Next sequential line always lives in the neighbouring bank
  always_comb begin
    prefetch_addr.mem_view.line_num = cpu_addr.mem_view.line_num + 1'b1;
    prefetch_addr.mem_view.offset   = '0;
  end

  always_comb begin
    prefetch                                  = '0;
    prefetch[prefetch_addr.bank_view.bank]    = cpu_waitrequest & ~hint_sent;
  end

  // A stalled request has already sent its hint
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      hint_sent <= 1'b0;
      rd_bank   <= '0;
    end else begin
      hint_sent <= cpu_waitrequest;
      if (accept)
        rd_bank <= sel_bank;
    end
  end

  // Answering bank is the one accepted last cycle
  assign cpu_rd_valid = bank_rd_valid[rd_bank];
  assign cpu_rd_line  = bank_rd_line[rd_bank];

  // Any answer must come from the bank that accepted the read
  a_one_answer: assert property (@(posedge clock) disable iff (!reset_n)
    $onehot0(bank_rd_valid) && (!(|bank_rd_valid) || bank_rd_valid[rd_bank]));

endmodule

// ==== hdl/banked_icache.sv ====
`timescale 1ns/1ps

module banked_icache #(
  parameter int NLINES = 64
) (
  input  logic                                clock,
  input  logic                                reset_n,
  input  logic [cache_pkg::ADDR_WIDTH-1:0]    cpu_addr,
  input  logic                                cpu_rd,
  input  logic                                invalidate,
  output logic                                cpu_waitrequest,
  output logic                                cpu_rd_valid,
  output logic [cache_pkg::LINE_WIDTH-1:0]    cpu_rd_line,
  output logic [cache_pkg::ADDR_WIDTH-1:0]    mem_addr,
  output logic                                mem_rd,
  input  logic                                mem_waitrequest,
  input  logic                                mem_rd_valid,
  input  logic [cache_pkg::WORD_WIDTH-1:0]    mem_rd_data
);

  cache_pkg::cpu_addr_t cpu_addr_u;
  cache_pkg::cpu_addr_t mem_addr_u;
  cache_pkg::cpu_addr_t lookup_addr;
  cache_pkg::cpu_addr_t prefetch_addr;

  logic [cache_pkg::NBANKS-1:0]                                hit_wait;
  logic [cache_pkg::NBANKS-1:0]                                bank_rd_valid;
  logic [cache_pkg::NBANKS-1:0][cache_pkg::LINE_WIDTH-1:0]     bank_rd_line;
  logic [cache_pkg::NBANKS-1:0]                                lookup_rd;
  logic [cache_pkg::NBANKS-1:0]                                prefetch;
  logic [cache_pkg::NBANKS-1:0]                                refill_req;
  logic [cache_pkg::NBANKS-1:0][cache_pkg::LINE_NUM_WIDTH-1:0] refill_line;
  logic [cache_pkg::NBANKS-1:0]                                refill_valid;
  logic [cache_pkg::WORD_WIDTH-1:0]                            refill_word;

  assign cpu_addr_u = cpu_addr;
  assign mem_addr   = mem_addr_u;

  bank_router u_router (
    .clock           (clock),
    .reset_n         (reset_n),
    .cpu_addr        (cpu_addr_u),
    .cpu_rd          (cpu_rd),
    .hit_wait        (hit_wait),
    .bank_rd_valid   (bank_rd_valid),
    .bank_rd_line    (bank_rd_line),
    .cpu_waitrequest (cpu_waitrequest),
    .cpu_rd_valid    (cpu_rd_valid),
    .cpu_rd_line     (cpu_rd_line),
    .lookup_rd       (lookup_rd),
    .lookup_addr     (lookup_addr),
    .prefetch        (prefetch),
    .prefetch_addr   (prefetch_addr)
  );

  for (genvar b = 0; b < cache_pkg::NBANKS; b++) begin : g_bank
    cache_bank #(
      .NLINES (NLINES)
    ) u_bank (
      .clock         (clock),
      .reset_n       (reset_n),
      .lookup_rd     (lookup_rd[b]),
      .lookup_addr   (lookup_addr),
      .prefetch      (prefetch[b]),
      .prefetch_addr (prefetch_addr),
      .invalidate    (invalidate),
      .refill_valid  (refill_valid[b]),
      .refill_word   (refill_word),
      .hit_wait      (hit_wait[b]),
      .rd_valid      (bank_rd_valid[b]),
      .rd_line       (bank_rd_line[b]),
      .refill_req    (refill_req[b]),
      .refill_line   (refill_line[b])
    );
  end

  refill_arbiter u_arbiter (
    .clock           (clock),
    .reset_n         (reset_n),
    .refill_req      (refill_req),
    .refill_line     (refill_line),
    .mem_waitrequest (mem_waitrequest),
    .mem_rd_valid    (mem_rd_valid),
    .mem_rd_data     (mem_rd_data),
    .refill_valid    (refill_valid),
    .refill_word     (refill_word),
    .mem_addr        (mem_addr_u),
    .mem_rd          (mem_rd)
  );

endmodule

// ==== hdl/cache_bank.sv ====
`timescale 1ns/1ps

module cache_bank #(
  parameter int NLINES = 64
) (
  input  logic                                clock,
  input  logic                                reset_n,
  input  logic                                lookup_rd,
  input  cache_pkg::cpu_addr_t                lookup_addr,
  input  logic                                prefetch,
  input  cache_pkg::cpu_addr_t                prefetch_addr,
  input  logic                                invalidate,
  input  logic                                refill_valid,
  input  logic [cache_pkg::WORD_WIDTH-1:0]    refill_word,
  output logic                                hit_wait,
  output logic                                rd_valid,
  output logic [cache_pkg::LINE_WIDTH-1:0]    rd_line,
  output logic                                refill_req,
  output logic [cache_pkg::LINE_NUM_WIDTH-1:0] refill_line
);

  localparam int INDEX_BITS = $clog2(NLINES);
  localparam int TAG_BITS   = cache_pkg::KEY_WIDTH - INDEX_BITS;
  localparam int WORD_BITS  = $clog2(cache_pkg::LINE_WORDS);

  logic [cache_pkg::LINE_WIDTH-1:0] line_data [NLINES];
  logic [TAG_BITS-1:0]              line_tag  [NLINES];
  logic [NLINES-1:0]                line_valid;

  logic [INDEX_BITS-1:0]  lk_index;
  logic [TAG_BITS-1:0]    lk_tag;
  logic                   lk_hit;
  logic [INDEX_BITS-1:0]  pf_index;
  logic [TAG_BITS-1:0]    pf_tag;
  logic                   pf_present;

  cache_pkg::cpu_addr_t   fill_addr;
  logic [INDEX_BITS-1:0]  fill_index;
  logic [TAG_BITS-1:0]    fill_tag;
  logic [WORD_BITS-1:0]   fill_count;
  logic                   fill_last;
  logic                   start_demand;
  logic                   start_prefetch;
  logic [INDEX_BITS-1:0]  start_index;

  // Lookup split of the line key
  assign lk_index = lookup_addr.bank_view.key[INDEX_BITS-1:0];
  assign lk_tag   = lookup_addr.bank_view.key[cache_pkg::KEY_WIDTH-1:INDEX_BITS];
  assign lk_hit   = line_valid[lk_index] && (line_tag[lk_index] == lk_tag);

  assign hit_wait = lookup_rd & ~lk_hit;

  // Presence check for the prefetch hint
  assign pf_index   = prefetch_addr.bank_view.key[INDEX_BITS-1:0];
  assign pf_tag     = prefetch_addr.bank_view.key[cache_pkg::KEY_WIDTH-1:INDEX_BITS];
  assign pf_present = line_valid[pf_index] && (line_tag[pf_index] == pf_tag);

  assign fill_index  = fill_addr.bank_view.key[INDEX_BITS-1:0];
  assign fill_tag    = fill_addr.bank_view.key[cache_pkg::KEY_WIDTH-1:INDEX_BITS];
  assign refill_line = fill_addr.mem_view.line_num;

  // Counter wraps on the fourth word
  assign fill_last = refill_valid & (&fill_count);

  // Demand misses win over hints, and one refill runs at a time
  assign start_demand   = hit_wait & ~refill_req & ~invalidate;
  assign start_prefetch = prefetch & ~pf_present & ~refill_req & ~invalidate & ~start_demand;
  assign start_index    = start_demand ? lk_index : pf_index;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      rd_valid   <= 1'b0;
      refill_req <= 1'b0;
      fill_count <= '0;
      line_valid <= '0;
    end else begin
      rd_valid <= lookup_rd & lk_hit;

      if (start_demand || start_prefetch) begin
        refill_req <= 1'b1;
        fill_count <= '0;
      end else if (refill_valid) begin
        fill_count <= fill_count + 1'b1;
        if (fill_last)
          refill_req <= 1'b0;
      end

      // Victim goes invalid while its words are overwritten
      if (invalidate)
        line_valid <= '0;
      else if (start_demand || start_prefetch)
        line_valid[start_index] <= 1'b0;
      else if (fill_last)
        line_valid[fill_index] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (start_demand)
      fill_addr <= lookup_addr;
    else if (start_prefetch)
      fill_addr <= prefetch_addr;

    if (lookup_rd && lk_hit)
      rd_line <= line_data[lk_index];

    // Word 0 lands in the low bits of the line
    if (refill_valid)
      line_data[fill_index][fill_count*cache_pkg::WORD_WIDTH +: cache_pkg::WORD_WIDTH] <=
        refill_word;

    if (fill_last)
      line_tag[fill_index] <= fill_tag;
  end

  a_fill_requested: assert property (@(posedge clock) disable iff (!reset_n)
    refill_valid |-> refill_req);

  a_no_inval_on_read: assert property (@(posedge clock) disable iff (!reset_n)
    !(invalidate && lookup_rd));

endmodule

// ==== hdl/cache_pkg.sv ====
package cache_pkg;

  // CPU and memory word geometry
  localparam int ADDR_WIDTH = 32;
  localparam int WORD_WIDTH = 32;

  // One line is four words, returned to the CPU as a whole
  localparam int LINE_WIDTH  = 128;
  localparam int LINE_WORDS  = LINE_WIDTH / WORD_WIDTH;
  localparam int OFFSET_BITS = 4;

  // Banks interleave on the line number bits just above the offset
  localparam int NBANKS    = 4;
  localparam int BANK_BITS = 2;

  // Line number is the address without its byte offset
  localparam int LINE_NUM_WIDTH = ADDR_WIDTH - OFFSET_BITS;

  // Part of the line number left once the bank bits are taken out
  localparam int KEY_WIDTH = LINE_NUM_WIDTH - BANK_BITS;

  // One address word, read either as a memory line number
  // or as a bank-interleaved key
  typedef union packed {
    struct packed {
      logic [LINE_NUM_WIDTH-1:0] line_num;
      logic [OFFSET_BITS-1:0]    offset;
    } mem_view;
    struct packed {
      // Index and tag are split out of the key inside each bank
      logic [KEY_WIDTH-1:0]   key;
      logic [BANK_BITS-1:0]   bank;
      logic [OFFSET_BITS-1:0] offset;
    } bank_view;
  } cpu_addr_t;

endpackage

// ==== hdl/refill_arbiter.sv ====
`timescale 1ns/1ps

module refill_arbiter (
  input  logic                                                        clock,
  input  logic                                                        reset_n,
  input  logic [cache_pkg::NBANKS-1:0]                                refill_req,
  input  logic [cache_pkg::NBANKS-1:0][cache_pkg::LINE_NUM_WIDTH-1:0] refill_line,
  input  logic                                                        mem_waitrequest,
  input  logic                                                        mem_rd_valid,
  input  logic [cache_pkg::WORD_WIDTH-1:0]                            mem_rd_data,
  output logic [cache_pkg::NBANKS-1:0]                                refill_valid,
  output logic [cache_pkg::WORD_WIDTH-1:0]                            refill_word,
  output cache_pkg::cpu_addr_t                                        mem_addr,
  output logic                                                        mem_rd
);

  localparam int WORD_BITS = $clog2(cache_pkg::LINE_WORDS);

  logic [cache_pkg::NBANKS-1:0]    grant;
  logic [cache_pkg::BANK_BITS-1:0] rr_ptr;
  logic [cache_pkg::BANK_BITS-1:0] pick;
  logic [cache_pkg::BANK_BITS-1:0] cand;
  logic                            pick_valid;
  logic                            idle;
  logic [WORD_BITS-1:0]            word_count;
  logic                            burst_last;
  logic                            burst_open;

  assign idle = (grant == '0);

  // First requester at or after the round-robin pointer
  always_comb begin
    pick_valid = 1'b0;
    pick       = rr_ptr;
    cand       = rr_ptr;
    for (int i = 0; i < cache_pkg::NBANKS; i++) begin
      cand = rr_ptr + i[cache_pkg::BANK_BITS-1:0];
      if (!pick_valid && refill_req[cand]) begin
        pick_valid = 1'b1;
        pick       = cand;
      end
    end
  end

  assign burst_last = mem_rd_valid & (&word_count);

  // Command taken, words still to come
  assign burst_open = ~idle & ~mem_rd;

  // All banks see the data, only the granted one writes it
  assign refill_valid = grant & {cache_pkg::NBANKS{mem_rd_valid}};
  assign refill_word  = mem_rd_data;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      grant      <= '0;
      rr_ptr     <= '0;
      mem_rd     <= 1'b0;
      word_count <= '0;
    end else if (idle) begin
      if (pick_valid) begin
        grant[pick] <= 1'b1;
        mem_rd      <= 1'b1;
        word_count  <= '0;
        rr_ptr      <= pick + 1'b1;
      end
    end else begin
      if (mem_rd && !mem_waitrequest)
        mem_rd <= 1'b0;
      if (mem_rd_valid) begin
        word_count <= word_count + 1'b1;
        if (burst_last)
          grant <= '0;
      end
    end
  end

  // Burst always starts at offset zero of the line
  always_ff @(posedge clock) begin
    if (idle && pick_valid) begin
      mem_addr.mem_view.line_num <= refill_line[pick];
      mem_addr.mem_view.offset   <= '0;
    end
  end

  // Granted bank keeps requesting for the whole burst
  a_grant_onehot: assert property (@(posedge clock) disable iff (!reset_n)
    $onehot0(grant) && ((grant & ~refill_req) == '0));

  a_data_in_burst: assert property (@(posedge clock) disable iff (!reset_n)
    mem_rd_valid |-> burst_open);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the banked instruction cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_banked_icache -f flist.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_banked_icache > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Everything OK" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== test/mem_model.sv ====
`timescale 1ns/1ps

module mem_model #(
  parameter logic [15:0] SEED = 16'd66
) (
  input  logic        clock,
  input  logic        reset_n,
  input  logic [31:0] mem_addr,
  input  logic        mem_rd,
  output logic        mem_waitrequest,
  output logic        mem_rd_valid,
  output logic [31:0] mem_rd_data
);

  logic [15:0] lfsr;
  logic [31:0] base;
  logic [1:0]  delay;

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] shift_lfsr(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_delay(output logic [1:0] v);
    for (int i = 0; i < 2; i++) begin
      lfsr = shift_lfsr(lfsr);
      v    = {v[0], lfsr[0]};
    end
  endtask

  initial begin
    lfsr            = SEED;
    mem_waitrequest = 1'b1;
    mem_rd_valid    = 1'b0;
    mem_rd_data     = '0;
    forever begin
      @(negedge clock);
      if (reset_n && mem_rd) begin
        // Wait states before the command is taken
        draw_delay(delay);
        repeat (delay) @(negedge clock);
        mem_waitrequest = 1'b0;
        base            = mem_addr;
        @(negedge clock);
        mem_waitrequest = 1'b1;
        // Four words in address order, random gaps between them
        for (int w = 0; w < 4; w++) begin
          draw_delay(delay);
          repeat (delay) @(negedge clock);
          mem_rd_valid = 1'b1;
          mem_rd_data  = (base + 32'(4 * w)) ^ 32'hA5A5_0000;
          @(negedge clock);
          mem_rd_valid = 1'b0;
        end
      end
    end
  end

endmodule

// ==== test/tb_banked_icache.sv ====
`timescale 1ns/1ps

module tb_banked_icache;

  localparam int NLINES     = 16;
  localparam int IDX        = $clog2(NLINES);
  localparam int LNW        = cache_pkg::LINE_NUM_WIDTH;
  localparam int N_RANDOM   = 200;
  localparam int N_READS    = N_RANDOM + 6;
  localparam int MAX_CYCLES = N_READS * 40 + 200;
  localparam logic [31:0] BASE = 32'h0001_0000;

  logic                            clock;
  logic                            reset_n;
  logic [31:0]                     cpu_addr;
  logic                            cpu_rd;
  logic                            invalidate;
  logic                            cpu_waitrequest;
  logic                            cpu_rd_valid;
  logic [cache_pkg::LINE_WIDTH-1:0] cpu_rd_line;
  logic [31:0]                     mem_addr;
  logic                            mem_rd;
  logic                            mem_waitrequest;
  logic                            mem_rd_valid;
  logic [31:0]                     mem_rd_data;

  logic                            accepted;
  logic                            prev_accepted;
  logic [31:0]                     last_addr;
  logic [cache_pkg::LINE_WIDTH-1:0] expect_line;
  logic [LNW-1:0]                  cpu_line;
  logic [LNW-1:0]                  next_line;
  logic [LNW-1:0]                  burst_line;
  logic                            cpu_line_present;
  logic                            next_line_present;
  logic                            cmd_line_present;
  logic                            cmd_taken;
  logic [2:0]                      words_left;
  logic                            expect_hit;
  logic                            expect_miss;
  logic [15:0]                     rng;
  logic [31:0]                     r;
  int                              data_errors = 0;
  int                              timing_errors = 0;
  int                              mem_errors = 0;

  // Presence table, line number per bank and index
  logic [LNW-1:0]    sb_line  [cache_pkg::NBANKS][NLINES];
  logic [NLINES-1:0] sb_valid [cache_pkg::NBANKS];

  banked_icache #(.NLINES(NLINES)) UUT (.*);

  mem_model #(.SEED(16'd66)) memory (.*);

  initial clock = 1'b0;
  always #4 clock = ~clock;

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic random_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      rng = lfsr_next(rng);
      v   = {v[30:0], rng[0]};
    end
  endtask

  function automatic logic is_present(input logic [LNW-1:0] line);
    return sb_valid[line[1:0]][line[IDX+1:2]] && (sb_line[line[1:0]][line[IDX+1:2]] == line);
  endfunction

  // Word 0 in the low bits, each word is its address XOR A5A50000
  function automatic logic [cache_pkg::LINE_WIDTH-1:0] expected_line(input logic [31:0] addr);
    logic [cache_pkg::LINE_WIDTH-1:0] line;
    for (int w = 0; w < 4; w++)
      line[w*32 +: 32] = ({addr[31:4], 4'h0} + 32'(4 * w)) ^ 32'hA5A5_0000;
    return line;
  endfunction

  assign accepted  = cpu_rd & ~cpu_waitrequest;
  assign cmd_taken = mem_rd & ~mem_waitrequest;
  assign cpu_line  = cpu_addr[31:4];
  assign next_line = cpu_line + 1'b1;

  always_comb begin
    cpu_line_present  = is_present(cpu_line);
    next_line_present = is_present(next_line);
    cmd_line_present  = is_present(mem_addr[31:4]);
    expect_line       = expected_line(last_addr);
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      prev_accepted <= 1'b0;
      words_left    <= '0;
      sb_valid      <= '{default: '0};
    end else begin
      prev_accepted <= accepted;
      if (accepted)
        last_addr <= cpu_addr;
      if (cmd_taken) begin
        words_left <= 3'd4;
        burst_line <= mem_addr[31:4];
      end else if (mem_rd_valid && words_left != 0) begin
        words_left <= words_left - 1'b1;
      end
      if (invalidate) begin
        sb_valid <= '{default: '0};
      end else begin
        // A stalled read may replace its own slot and the next line's slot
        if (cpu_rd && cpu_waitrequest) begin
          sb_valid[cpu_line[1:0]][cpu_line[IDX+1:2]] <= 1'b0;
          if (!next_line_present)
            sb_valid[next_line[1:0]][next_line[IDX+1:2]] <= 1'b0;
        end
        if (mem_rd_valid && words_left == 3'd1) begin
          sb_valid[burst_line[1:0]][burst_line[IDX+1:2]] <= 1'b1;
          sb_line[burst_line[1:0]][burst_line[IDX+1:2]]  <= burst_line;
        end
      end
    end
  end

  a_valid_timing: assert property (@(posedge clock) disable iff (!reset_n)
    cpu_rd_valid == prev_accepted)
    else begin
      timing_errors++;
      $display("cpu_rd_valid did not come exactly one cycle after acceptance at %0t", $time);
    end

  a_line_data: assert property (@(posedge clock) disable iff (!reset_n)
    cpu_rd_valid |-> cpu_rd_line == expect_line)
    else begin
      data_errors++;
      $display("mismatch cpu_rd_line expected %h actual %h",
        $sampled(expect_line), $sampled(cpu_rd_line));
    end

  a_present_hits: assert property (@(posedge clock) disable iff (!reset_n)
    (cpu_rd && (cpu_line_present || expect_hit)) |-> !cpu_waitrequest)
    else begin
      timing_errors++;
      $display("read of a present line %h was stalled", $sampled(cpu_addr));
    end

  a_stale_miss: assert property (@(posedge clock) disable iff (!reset_n)
    (cpu_rd && expect_miss) |-> cpu_waitrequest)
    else begin
      timing_errors++;
      $display("read after invalidate hit without a refill at %0t", $time);
    end

  a_single_fill: assert property (@(posedge clock) disable iff (!reset_n)
    cmd_taken |-> (!cmd_line_present && words_left == 0))
    else begin
      mem_errors++;
      $display("memory command for a present line or during a burst at %0t", $time);
    end

  a_line_aligned: assert property (@(posedge clock) disable iff (!reset_n)
    mem_rd |-> mem_addr[3:0] == 4'h0)
    else begin
      mem_errors++;
      $display("mismatch mem_addr expected offset 0 actual %h", $sampled(mem_addr));
    end

  a_words_in_burst: assert property (@(posedge clock) disable iff (!reset_n)
    mem_rd_valid |-> words_left != 0)
    else begin
      mem_errors++;
      $display("memory word returned outside a burst at %0t", $time);
    end

  // Mode 1 expects a hit, mode 2 a miss, both checked in the first cycle
  task automatic read_line(input logic [31:0] addr, input int mode);
    cpu_addr    = addr;
    cpu_rd      = 1'b1;
    expect_hit  = (mode == 1);
    expect_miss = (mode == 2);
    @(negedge clock);
    expect_hit  = 1'b0;
    expect_miss = 1'b0;
    while (!prev_accepted)
      @(negedge clock);
    cpu_rd = 1'b0;
  endtask

  task automatic wait_quiet();
    int quiet;
    quiet = 0;
    while (quiet < 4) begin
      @(negedge clock);
      if (!mem_rd && words_left == 0)
        quiet++;
      else
        quiet = 0;
    end
  endtask

  initial begin
    cpu_addr    = '0;
    cpu_rd      = 1'b0;
    invalidate  = 1'b0;
    expect_hit  = 1'b0;
    expect_miss = 1'b0;
    reset_n     = 1'b0;
    rng         = 16'd66;
    repeat (8) @(posedge clock);
    @(negedge clock);
    reset_n = 1'b1;

    // Demand miss, then the prefetched next line and the line itself hit
    read_line(BASE + 32'h230, 0);
    wait_quiet();
    read_line(BASE + 32'h248, 1);
    read_line(BASE + 32'h23C, 1);
    wait_quiet();

    invalidate = 1'b1;
    @(negedge clock);
    invalidate = 1'b0;
    read_line(BASE + 32'h230, 2);

    // Same bank and index, other tag
    read_line(BASE + 32'h630, 2);
    read_line(BASE + 32'h230, 2);

    for (int n = 0; n < N_RANDOM; n++) begin
      random_bits(12, r);
      read_line(BASE + {20'h0, r[11:0]}, 0);
    end
    repeat (2) @(negedge clock);

    $display("errors: data %0d, timing %0d, memory %0d", data_errors, timing_errors, mem_errors);
    if (data_errors + timing_errors + mem_errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

  initial begin
    repeat (MAX_CYCLES) @(posedge clock);
    $display("Watchdog expired after %0d cycles", MAX_CYCLES);
    $display("Something failed");
    $finish;
  end

endmodule
